/* filelist.f */
verilog/cfg_pkg.sv
verilog/cfg_reg_decode.sv
verilog/cfg_unlock.sv
verilog/cfg_mailbox.sv
verilog/cfg_readback.sv
verilog/cfg_cmd_engine.sv
verilog/cfg_top.sv
verif/cfg_tb.sv

/* verif/cfg_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_tb;

    logic              clk;
    logic              reset;
    logic              host_reset;
    logic              host_nmi;
    cfg_pkg::reg_req_t bus;
    logic [15:0]       rdata;
    logic              irq;

    int          fd;
    int          code;
    string       op;
    string       line;
    logic [15:0] idx;
    logic [15:0] data;
    logic [15:0] exp_v;
    int          test_id;
    int          test_errors;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    cfg_top #(
        .VERSION        (32'hA5C3_0102),
        .ENGINE_LATENCY (3)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .host_reset (host_reset),
        .host_nmi   (host_nmi),
        .bus        (bus),
        .rdata      (rdata),
        .irq        (irq)
    );

    always #10 clk = ~clk;

    // strobes fall back to idle every cycle unless an operation sets them again
    task automatic next_cycle();
        @(posedge clk);
        #2;
        bus.write  = 1'b0;
        host_reset = 1'b0;
        host_nmi   = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        checks++;
        if (got !== want) begin
            $display("Mismatch %s: got 0x%04h, expected 0x%04h (test %0d)",
                     name, got, want, test_id);
            test_errors++;
        end
    endtask

    function automatic logic [16:0] reg_address(input logic [3:0] r);
        return {1'b1, 11'd0, r, 1'b0};
    endfunction

    task automatic write_reg(input logic [3:0] r, input logic [15:0] value);
        next_cycle();
        bus.write   = 1'b1;
        bus.address = reg_address(r);
        bus.wdata   = value;
    endtask

    // rdata is combinational, so it is taken at the falling edge
    task automatic read_reg(input logic [3:0] r, output logic [15:0] value);
        next_cycle();
        bus.address = reg_address(r);
        @(negedge clk);
        value = rdata;
    endtask

    task automatic wait_done(input logic [15:0] want);
        logic [15:0] status_v;
        int          polls;
        polls = 0;
        read_reg(4'd0, status_v);
        while (status_v[15] && (polls < 100)) begin
            polls++;
            read_reg(4'd0, status_v);
        end
        if (status_v[15]) begin
            $display("test %0d: the command was still pending after 100 cycles", test_id);
            test_errors++;
        end else begin
            check_value("rdata (status)", status_v, want);
        end
    endtask

    task automatic close_test();
        if (test_id != 0) begin
            tests_run++;
            errors += test_errors;
            if (test_errors == 0) begin
                $display("test %0d passed", test_id);
            end else begin
                tests_failed++;
                $display("test %0d failed with %0d errors", test_id, test_errors);
            end
        end
        test_errors = 0;
    endtask

    task automatic run_line();
        logic [15:0] value;
        if (op == "test") begin
            close_test();
            test_id = idx;
        end else if (op == "write") begin
            write_reg(idx[3:0], data);
        end else if (op == "read") begin
            read_reg(idx[3:0], value);
            check_value($sformatf("rdata (reg %0d)", idx), value, exp_v);
        end else if (op == "wait_done") begin
            wait_done(exp_v);
        end else if (op == "irq") begin
            next_cycle();
            @(negedge clk);
            check_value("irq", {15'd0, irq}, exp_v);
        end else if (op == "host_reset") begin
            next_cycle();
            host_reset = 1'b1;
        end else if (op == "nmi") begin
            next_cycle();
            host_nmi = 1'b1;
        end else begin
            $display("test %0d: unknown operation %s in the tests file", test_id, op);
            test_errors++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        host_reset   = 1'b0;
        host_nmi     = 1'b0;
        bus          = '0;
        test_id      = 0;
        test_errors  = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        fd = $fopen("verif/cfg_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/cfg_tests.txt");
            errors++;
        end else begin
            code = $fscanf(fd, "%s", op);
            while (code == 1) begin
                if (op.getc(0) == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h", idx, data, exp_v);
                    run_line();
                end
                code = $fscanf(fd, "%s", op);
            end
            $fclose(fd);
            next_cycle();
        end
        close_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if ((errors == 0) && (tests_run > 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/cfg_tests.txt */
# op reg data expect, with reg, data and expect in hex
# reg 0 status, 1 command, 2-5 data0_h to data1_l, 6-7 version, 8-9 key
test 1 0 0
write 3 1111 0
write 1 0001 0
read 0 0 0000
read 1 0 0000
read 6 0 a5c3
read 7 0 0102
write 8 5f55 0
write 9 4e4c 0
write 8 1234 0
write 9 4f43 0
write 8 4b5f 0
read 0 0 0000
write 1 0003 0
read 0 0 0000
write 8 5f55 0
write 9 4e4c 0
nmi 0 0 0
write 8 4f43 0
write 9 4b5f 0
read 0 0 0000
write 1 0003 0
read 0 0 0000
test 2 0 0
write 8 5f55 0
write 9 4e4c 0
write 8 4f43 0
write 9 4b5f 0
read 0 0 0000
write 2 1234 0
write 3 abcd 0
write 4 0000 0
write 5 0007 0
write 1 0001 0
read 0 0 8000
wait_done 0 0 0000
write 1 0002 0
wait_done 0 0 0000
read 2 0 1234
read 3 0 abcd
read 4 0 0000
read 5 0 0007
test 3 0 0
write 1 005a 0
wait_done 0 0 4000
read 1 0 005a
write 1 0000 0
read 0 0 8000
wait_done 0 0 0000
test 4 0 0
write 1 0003 0
wait_done 0 0 2000
irq 0 0 1
write 7 0000 0
read 0 0 0000
irq 0 0 0
test 5 0 0
write 9 ffff 0
write 8 ffff 0
write 2 dead 0
write 3 beef 0
write 1 0001 0
read 0 0 0000
write 8 5f55 0
write 9 4e4c 0
write 8 4f43 0
write 9 4b5f 0
read 0 0 0000
write 1 0002 0
read 0 0 8000
wait_done 0 0 0000
read 2 0 1234
read 3 0 abcd
test 6 0 0
write 1 0003 0
wait_done 0 0 2000
irq 0 0 1
host_reset 0 0 0
read 0 0 0000
read 1 0 0000
irq 0 0 0
write 1 0001 0
read 0 0 0000

/* verilog/cfg_cmd_engine.sv */
`timescale 1ns/1ps
`default_nettype none

// ENGINE_LATENCY must be at least 2
module cfg_cmd_engine #(
    parameter int ENGINE_LATENCY = 3
) (
    input  wire               clk,
    input  wire               reset,
    input  wire cfg_pkg::cmd_req_t cmd_req,
    output cfg_pkg::cmd_rsp_t cmd_rsp
);

    localparam int CNT_W = $clog2(ENGINE_LATENCY + 1);

    logic [31:0]      store_mem [16];
    logic             pending_q;
    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [7:0]       cmd_q;
    logic [31:0]      data0_q;
    logic [31:0]      data1_q;
    logic             start;
    logic             finish;
    logic             known_op;
    logic             done;
    logic             error;
    logic             irq_pulse;
    logic [31:0]      reply0;
    logic [31:0]      reply1;

    // a command overwritten while busy never produces a new rising edge
    assign start  = cmd_req.pending && !pending_q && !busy;
    assign finish = busy && (cnt == CNT_W'(1));

    assign known_op = cmd_q inside {cfg_pkg::nop, cfg_pkg::store, cfg_pkg::load, cfg_pkg::irq};

    assign cmd_rsp = '{
        done:   done,
        error:  error,
        irq:    irq_pulse,
        reply0: reply0,
        reply1: reply1
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 1'b0;
            busy      <= 1'b0;
            cnt       <= '0;
            done      <= 1'b0;
            error     <= 1'b0;
            irq_pulse <= 1'b0;
            reply0    <= 32'd0;
            reply1    <= 32'd0;
        end else begin
            pending_q <= cmd_req.pending;
            done      <= finish;
            error     <= finish && !known_op;
            irq_pulse <= finish && (cmd_q == cfg_pkg::irq);

            // the edge that latches the command counts as the first cycle
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(ENGINE_LATENCY - 1);
            end else if (finish) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end

            if (finish && (cmd_q == cfg_pkg::load)) begin
                reply0 <= store_mem[data1_q[3:0]];
                reply1 <= data1_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cmd_q   <= cmd_req.cmd;
            data0_q <= cmd_req.data0;
            data1_q <= cmd_req.data1;
        end

        if (finish && (cmd_q == cfg_pkg::store)) begin
            store_mem[data1_q[3:0]] <= data0_q;
        end
    end

    // the mailbox must see exactly one completion per command
    a_done_single: assert property (
        @(posedge clk) disable iff (reset) cmd_rsp.done |=> !cmd_rsp.done
    );

endmodule

`default_nettype wire

/* verilog/cfg_mailbox.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_mailbox (
    input  wire               clk,
    input  wire               reset,
    input  wire               host_reset,
    input  wire               wr,
    input  wire cfg_pkg::cfg_reg_e reg_idx,
    input  wire  [15:0]       wdata,
    input  wire cfg_pkg::cmd_rsp_t cmd_rsp,
    output cfg_pkg::cmd_req_t cmd_req,
    output logic              error,
    output logic              irq
);

    logic        pending;
    logic [7:0]  cmd;
    logic [31:0] data0;
    logic [31:0] data1;

    assign cmd_req = '{
        pending: pending,
        cmd:     cmd,
        data0:   data0,
        data1:   data1
    };

    always_ff @(posedge clk) begin
        if (reset || host_reset) begin
            pending <= 1'b0;
            cmd     <= 8'h00;
            error   <= 1'b0;
            irq     <= 1'b0;
        end else begin
            if (cmd_rsp.done) begin
                pending <= 1'b0;
                error   <= cmd_rsp.error;
            end

            if (cmd_rsp.irq) begin
                irq <= 1'b1;
            end

            // host writes come last so they win over an engine event at the same edge
            if (wr) begin
                case (reg_idx)
                    cfg_pkg::command: begin
                        pending <= 1'b1;
                        cmd     <= wdata[7:0];
                        error   <= 1'b0;
                    end
                    cfg_pkg::version_l: irq <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // the host data words are only read by the engine
    always_ff @(posedge clk) begin
        if (wr) begin
            case (reg_idx)
                cfg_pkg::data0_h: data0[31:16] <= wdata;
                cfg_pkg::data0_l: data0[15:0]  <= wdata;
                cfg_pkg::data1_h: data1[31:16] <= wdata;
                cfg_pkg::data1_l: data1[15:0]  <= wdata;
                default: ;
            endcase
        end
    end

    // the engine only finishes a command that the host posted
    a_done_needs_pending: assert property (
        @(posedge clk) disable iff (reset || host_reset) cmd_rsp.done |-> pending
    );

endmodule

`default_nettype wire

/* verilog/cfg_pkg.sv */
`default_nettype none

package cfg_pkg;

    // register index, taken from address bits 4:1 inside the window
    typedef enum logic [3:0] {
        status    = 4'd0,
        command   = 4'd1,
        data0_h   = 4'd2,
        data0_l   = 4'd3,
        data1_h   = 4'd4,
        data1_l   = 4'd5,
        version_h = 4'd6,
        version_l = 4'd7,
        key_h     = 4'd8,
        key_l     = 4'd9
    } cfg_reg_e;

    // the host must write these in order to open the mailbox
    localparam logic [15:0] unlock_key [4] = '{
        16'h5F55,
        16'h4E4C,
        16'h4F43,
        16'h4B5F
    };

    // two of these in a row to a key register lock the mailbox again
    localparam logic [15:0] LOCK_WORD = 16'hFFFF;

    typedef enum logic [7:0] {
        nop   = 8'h00,
        store = 8'h01,
        load  = 8'h02,
        irq   = 8'h03
    } cfg_opcode_e;

    typedef struct packed {
        logic        write;
        logic [16:0] address;
        logic [15:0] wdata;
    } reg_req_t;

    // the opcode byte is kept raw so unknown values reach the engine
    typedef struct packed {
        logic        pending;
        logic [7:0]  cmd;
        logic [31:0] data0;
        logic [31:0] data1;
    } cmd_req_t;

    typedef struct packed {
        logic        done;
        logic        error;
        logic        irq;
        logic [31:0] reply0;
        logic [31:0] reply1;
    } cmd_rsp_t;

endpackage

`default_nettype wire

/* verilog/cfg_readback.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_readback #(
    parameter logic [31:0] VERSION = 32'h0001_0000
) (
    input  wire               hit,
    input  wire cfg_pkg::cfg_reg_e reg_idx,
    input  wire cfg_pkg::cmd_req_t cmd_req,
    input  wire cfg_pkg::cmd_rsp_t cmd_rsp,
    input  wire               error,
    input  wire               irq,
    output logic [15:0]       rdata
);

    // reads have no wait state so the mux feeds the bus directly
    always_comb begin
        rdata = 16'h0000;
        if (hit) begin
            case (reg_idx)
                cfg_pkg::status: begin
                    rdata = {cmd_req.pending, error, irq, 13'd0};
                end
                cfg_pkg::command: begin
                    rdata = {8'h00, cmd_req.cmd};
                end
                cfg_pkg::data0_h:   rdata = cmd_rsp.reply0[31:16];
                cfg_pkg::data0_l:   rdata = cmd_rsp.reply0[15:0];
                cfg_pkg::data1_h:   rdata = cmd_rsp.reply1[31:16];
                cfg_pkg::data1_l:   rdata = cmd_rsp.reply1[15:0];
                cfg_pkg::version_h: rdata = VERSION[31:16];
                cfg_pkg::version_l: rdata = VERSION[15:0];
                // key registers are write only
                default:            rdata = 16'h0000;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/cfg_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_reg_decode (
    input  wire               clk,
    input  wire cfg_pkg::reg_req_t bus,
    output logic              hit,
    output cfg_pkg::cfg_reg_e reg_idx,
    output logic              wr
);

    // the window is address bit 16 set with bits 15:5 clear
    assign hit = bus.address[16] && (bus.address[15:5] == 11'd0);

    // bit 0 is the byte lane within a 16-bit register and is ignored
    assign reg_idx = cfg_pkg::cfg_reg_e'(bus.address[4:1]);

    assign wr = bus.write && hit;

    // a write strobe outside the register window would reach the mailbox
    // and the unlock logic with a meaningless index
    a_wr_in_window: assert property (
        @(posedge clk) wr |-> hit
    );

endmodule

`default_nettype wire

/* verilog/cfg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_top #(
    parameter logic [31:0] VERSION        = 32'h0001_0003,
    parameter int          ENGINE_LATENCY = 3
) (
    input  wire               clk,
    input  wire               reset,
    input  wire               host_reset,
    input  wire               host_nmi,
    input  wire cfg_pkg::reg_req_t bus,
    output logic [15:0]       rdata,
    output logic              irq
);

    logic              hit;
    logic              wr;
    logic              unlocked;
    logic              error;
    cfg_pkg::cfg_reg_e reg_idx;
    cfg_pkg::cmd_req_t cmd_req;
    cfg_pkg::cmd_rsp_t cmd_rsp;

    cfg_reg_decode u_decode (
        .clk     (clk),
        .bus     (bus),
        .hit     (hit),
        .reg_idx (reg_idx),
        .wr      (wr)
    );

    cfg_unlock u_unlock (
        .clk        (clk),
        .reset      (reset),
        .host_reset (host_reset),
        .host_nmi   (host_nmi),
        .wr         (wr),
        .reg_idx    (reg_idx),
        .wdata      (bus.wdata),
        .unlocked   (unlocked)
    );

    // while locked the mailbox sees no writes at all
    cfg_mailbox u_mailbox (
        .clk        (clk),
        .reset      (reset),
        .host_reset (host_reset),
        .wr         (wr && unlocked),
        .reg_idx    (reg_idx),
        .wdata      (bus.wdata),
        .cmd_rsp    (cmd_rsp),
        .cmd_req    (cmd_req),
        .error      (error),
        .irq        (irq)
    );

    // a host reset also abandons a command in flight
    cfg_cmd_engine #(
        .ENGINE_LATENCY (ENGINE_LATENCY)
    ) u_engine (
        .clk     (clk),
        .reset   (reset || host_reset),
        .cmd_req (cmd_req),
        .cmd_rsp (cmd_rsp)
    );

    cfg_readback #(
        .VERSION (VERSION)
    ) u_readback (
        .hit     (hit),
        .reg_idx (reg_idx),
        .cmd_req (cmd_req),
        .cmd_rsp (cmd_rsp),
        .error   (error),
        .irq     (irq),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

/* verilog/cfg_unlock.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_unlock (
    input  wire               clk,
    input  wire               reset,
    input  wire               host_reset,
    input  wire               host_nmi,
    input  wire               wr,
    input  wire cfg_pkg::cfg_reg_e reg_idx,
    input  wire  [15:0]       wdata,
    output logic              unlocked
);

    logic       key_wr;
    logic [1:0] key_cnt;
    logic       key_done;
    logic       lock_cnt;

    assign key_wr = wr && ((reg_idx == cfg_pkg::key_h) || (reg_idx == cfg_pkg::key_l));

    always_ff @(posedge clk) begin
        if (reset || host_reset) begin
            key_cnt  <= 2'd0;
            key_done <= 1'b0;
            lock_cnt <= 1'b0;
            unlocked <= 1'b0;
        end else begin
            key_done <= 1'b0;

            // the fourth key word opens the mailbox one cycle later
            if (key_done) begin
                unlocked <= 1'b1;
            end

            if (host_nmi) begin
                key_cnt <= 2'd0;
            end else if (!unlocked && key_wr) begin
                if (wdata == cfg_pkg::unlock_key[key_cnt]) begin
                    // wraps back to zero after the last word
                    key_cnt <= key_cnt + 2'd1;
                    if (key_cnt == 2'd3) begin
                        key_done <= 1'b1;
                    end
                end else begin
                    key_cnt <= 2'd0;
                end
            end

            if (unlocked && key_wr) begin
                if (wdata != cfg_pkg::LOCK_WORD) begin
                    lock_cnt <= 1'b0;
                end else if (lock_cnt) begin
                    lock_cnt <= 1'b0;
                    unlocked <= 1'b0;
                end else begin
                    lock_cnt <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
